// ==== src/ss_pkg.sv ====
package ss_pkg;

  // one host bridge data word
  localparam int BRIDGE_W = 32;

  // one word as the core's save state manager sees it
  localparam int SS_W = 64;

  // byte counts of the two word sizes
  localparam int HALF_BYTES = BRIDGE_W / 8;
  localparam int SS_BYTES = SS_W / 8;

  // bridge_addr[31:28] value that selects save state data
  localparam logic [3:0] REGION_NIBBLE = 4'h4;

  // 64-bit save state word, decoded two ways
  // halves[0] holds the first bridge word of a pair,
  // halves[1] the second one
  // bytes[0] is bits 7:0, bytes[7] is bits 63:56
  // the FIFO packs through halves and swaps through bytes
  typedef union packed {
    // pair of bridge words
    logic [1:0][BRIDGE_W-1:0] halves;
    // flat byte lanes
    logic [SS_BYTES-1:0][7:0] bytes;
  } ss_word_u;

  // host sends big endian words, so the bytes inside each
  // 32-bit half come out reversed towards the core
  //   ss byte 0 <- half byte 3
  //   ss byte 1 <- half byte 2
  //   ss byte 2 <- half byte 1
  //   ss byte 3 <- half byte 0
  // same again for bytes 4..7 within the upper half
  // the half order itself is kept

endpackage

// ==== src/ss_write_fifo.sv ====
`timescale 1ns/10ps

module ss_write_fifo #(
  // log2 of depth in 32-bit words
  parameter int FIFO_DEPTH_W = 11
) (
  input  logic                        clk_74a,
  input  logic                        reset,

  // host bridge write side
  input  logic                        bridge_wr,
  input  logic [31:0]                 bridge_addr,
  input  logic [ss_pkg::BRIDGE_W-1:0] bridge_wr_data,

  // 64-bit read side
  input  logic                        rd_en,
  output ss_pkg::ss_word_u            rd_data,
  output logic                        empty,
  output logic                        overflow
);

  import ss_pkg::*;

  // storage is split into even and odd word banks,
  // so one read address fetches a whole pair
  localparam int PAIRS = 1 << (FIFO_DEPTH_W - 1);

  // word count of a completely filled FIFO
  localparam logic [FIFO_DEPTH_W:0] FULL_COUNT = {1'b1, {FIFO_DEPTH_W{1'b0}}};

  // first word of each pair
  logic [BRIDGE_W-1:0] mem_even [0:PAIRS-1];
  // second word of each pair
  logic [BRIDGE_W-1:0] mem_odd [0:PAIRS-1];

  // write pointer in words, read pointer in pairs,
  // both with one extra wrap bit
  logic [FIFO_DEPTH_W:0]   wr_ptr;
  logic [FIFO_DEPTH_W-1:0] rd_ptr;

  logic [FIFO_DEPTH_W-2:0] wr_idx;
  logic [FIFO_DEPTH_W-2:0] rd_idx;
  logic [FIFO_DEPTH_W:0]   used;
  logic                    full;
  logic                    wr_hit;
  logic                    wr_accept;

  ss_word_u pair_raw;
  ss_word_u pair_swapped;

  // region decode on the top address nibble
  assign wr_hit = bridge_wr && (bridge_addr[31:28] == REGION_NIBBLE);
  // the bridge has no back-pressure so a write into a full FIFO is lost
  assign wr_accept = wr_hit && !full;

  // bank address drops the even/odd bit
  assign wr_idx = wr_ptr[FIFO_DEPTH_W-1:1];
  assign rd_idx = rd_ptr[FIFO_DEPTH_W-2:0];

  // fill level in words
  assign used = wr_ptr - {rd_ptr, 1'b0};
  assign full = (used == FULL_COUNT);
  // a lone first word of a pair does not count
  assign empty = (used[FIFO_DEPTH_W:1] == '0);

  // word storage
  always_ff @(posedge clk_74a) begin
    if (wr_accept) begin
      if (wr_ptr[0]) begin
        mem_odd[wr_idx] <= bridge_wr_data;
      end else begin
        mem_even[wr_idx] <= bridge_wr_data;
      end
    end
  end

  // pointers and overflow flag
  always_ff @(posedge clk_74a) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // one step = one pair
      if (rd_en && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // single cycle pulse per dropped word
      overflow <= wr_hit && full;
    end
  end

  // pack the pair, then reverse bytes inside each half
  always_comb begin
    pair_raw.halves[0] = mem_even[rd_idx];
    pair_raw.halves[1] = mem_odd[rd_idx];
    for (int i = 0; i < SS_BYTES; i++) begin
      // xor flips the lane order within a half only
      pair_swapped.bytes[i] = pair_raw.bytes[i ^ (HALF_BYTES - 1)];
    end
  end

  // read port register holds its word until the next read
  always_ff @(posedge clk_74a) begin
    if (rd_en) begin
      rd_data <= pair_swapped;
    end
  end

  // sequencer must only pop a stored pair
  a_rd_not_empty: assert property (
    @(posedge clk_74a) disable iff (reset)
    rd_en |-> !empty
  );

  // a dropped bridge word never moves the write pointer
  a_overflow_cause: assert property (
    @(posedge clk_74a) disable iff (reset)
    overflow |-> $past(bridge_wr) && $stable(wr_ptr)
  );

endmodule

// ==== src/ss_load_sequencer.sv ====
`timescale 1ns/10ps

module ss_load_sequencer (
  input  logic                    clk_74a,
  input  logic                    reset,

  // FIFO side
  input  logic                    empty,
  input  logic                    overflow,
  input  ss_pkg::ss_word_u        rd_data,
  output logic                    rd_en,

  // core save state manager
  output logic                    ss_load,
  input  logic                    ss_req,
  output logic                    ss_ack,
  output logic [ss_pkg::SS_W-1:0] ss_dout,
  input  logic                    ss_busy,

  // host load handshake
  input  logic                    savestate_load,
  output logic                    savestate_load_ack,
  output logic                    savestate_load_busy,
  output logic                    savestate_load_ok,
  output logic                    savestate_load_err
);

  // no session running
  localparam logic [2:0] ST_IDLE      = 3'd0;
  // manager running, waiting for a word request
  localparam logic [2:0] ST_WAIT_REQ  = 3'd1;
  // FIFO pop issued, ack goes out next
  localparam logic [2:0] ST_READ      = 3'd2;
  // data phase over, waiting for the host to start the load
  localparam logic [2:0] ST_WAIT_HOST = 3'd3;
  localparam logic [2:0] ST_HOST_BUSY = 3'd4;
  localparam logic [2:0] ST_COMPLETE  = 3'd5;

  logic [2:0] state;

  // request seen while no word was ready
  logic req_pending;

  // edge detect history
  logic prev_ss_busy;
  logic prev_savestate_load;

  logic busy_fall;
  logic load_rise;

  assign busy_fall = prev_ss_busy && !ss_busy;
  assign load_rise = savestate_load && !prev_savestate_load;

  // FIFO read register already holds the word in core byte order
  assign ss_dout = rd_data;

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      state               <= ST_IDLE;
      req_pending         <= 1'b0;
      prev_ss_busy        <= 1'b0;
      prev_savestate_load <= 1'b0;
      rd_en               <= 1'b0;
      ss_load             <= 1'b0;
      ss_ack              <= 1'b0;
      savestate_load_ack  <= 1'b0;
      savestate_load_busy <= 1'b0;
      savestate_load_ok   <= 1'b0;
      savestate_load_err  <= 1'b0;
    end else begin
      prev_ss_busy        <= ss_busy;
      prev_savestate_load <= savestate_load;

      // single cycle strobes
      ss_load <= 1'b0;
      ss_ack  <= 1'b0;
      rd_en   <= 1'b0;

      case (state)
        ST_IDLE: begin
          // first full pair opens a session
          // an aborted load stays reported and blocks a restart
          if (!empty && !savestate_load_err) begin
            ss_load           <= 1'b1;
            savestate_load_ok <= 1'b0;
            req_pending       <= 1'b0;
            state             <= ST_WAIT_REQ;
          end
        end

        ST_WAIT_REQ: begin
          if (busy_fall) begin
            // manager finished, hand over to the host
            req_pending <= 1'b0;
            state       <= ST_WAIT_HOST;
          end else if (!empty && (req_pending || ss_req)) begin
            rd_en <= 1'b1;
            // a fresh request on top of a pending one stays queued
            req_pending <= req_pending && ss_req;
            state       <= ST_READ;
          end else if (ss_req) begin
            // nothing to give yet
            req_pending <= 1'b1;
          end
        end

        ST_READ: begin
          // rd_data valid this cycle
          ss_ack <= 1'b1;
          if (ss_req) begin
            req_pending <= 1'b1;
          end
          if (busy_fall) begin
            state <= ST_WAIT_HOST;
          end else begin
            state <= ST_WAIT_REQ;
          end
        end

        ST_WAIT_HOST: begin
          if (load_rise) begin
            savestate_load_ack <= 1'b1;
            state              <= ST_HOST_BUSY;
          end
        end

        ST_HOST_BUSY: begin
          savestate_load_ack  <= 1'b0;
          savestate_load_busy <= 1'b1;
          state               <= ST_COMPLETE;
        end

        ST_COMPLETE: begin
          // ok held until the next session
          savestate_load_busy <= 1'b0;
          savestate_load_ok   <= 1'b1;
          state               <= ST_IDLE;
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase

      // lost bridge data, abort from any state
      if (overflow) begin
        state               <= ST_IDLE;
        req_pending         <= 1'b0;
        rd_en               <= 1'b0;
        ss_ack              <= 1'b0;
        savestate_load_ack  <= 1'b0;
        savestate_load_busy <= 1'b0;
        savestate_load_ok   <= 1'b0;
        savestate_load_err  <= 1'b1;
      end
    end
  end

  // one ack per word
  a_ack_single: assert property (
    @(posedge clk_74a) disable iff (reset)
    ss_ack |=> !ss_ack
  );

  // each ack answers a FIFO pop from the cycle before
  a_ack_after_read: assert property (
    @(posedge clk_74a) disable iff (reset)
    ss_ack |-> $past(rd_en)
  );

endmodule

// ==== src/save_state_controller.sv ====
`timescale 1ns/10ps

module save_state_controller #(
  // log2 of FIFO depth in bridge words
  parameter int FIFO_DEPTH_W = 11
) (
  input  logic                        clk_74a,
  input  logic                        reset,

  // host bridge
  input  logic                        bridge_wr,
  input  logic [31:0]                 bridge_addr,
  input  logic [ss_pkg::BRIDGE_W-1:0] bridge_wr_data,

  // host load handshake
  input  logic                        savestate_load,
  output logic                        savestate_load_ack,
  output logic                        savestate_load_busy,
  output logic                        savestate_load_ok,
  output logic                        savestate_load_err,

  // core save state manager
  output logic                        ss_load,
  input  logic                        ss_req,
  output logic                        ss_ack,
  output logic [ss_pkg::SS_W-1:0]     ss_dout,
  input  logic                        ss_busy
);

  import ss_pkg::*;

  // FIFO to sequencer
  logic     fifo_empty;
  logic     fifo_overflow;
  logic     fifo_rd_en;
  ss_word_u fifo_rd_data;

  // bridge words in, swapped 64-bit words out
  ss_write_fifo #(
    .FIFO_DEPTH_W(FIFO_DEPTH_W)
  ) i_fifo (
    .clk_74a       (clk_74a),
    .reset         (reset),
    .bridge_wr     (bridge_wr),
    .bridge_addr   (bridge_addr),
    .bridge_wr_data(bridge_wr_data),
    .rd_en         (fifo_rd_en),
    .rd_data       (fifo_rd_data),
    .empty         (fifo_empty),
    .overflow      (fifo_overflow)
  );

  // session control towards core and host
  ss_load_sequencer i_seq (
    .clk_74a            (clk_74a),
    .reset              (reset),
    .empty              (fifo_empty),
    .overflow           (fifo_overflow),
    .rd_data            (fifo_rd_data),
    .rd_en              (fifo_rd_en),
    .ss_load            (ss_load),
    .ss_req             (ss_req),
    .ss_ack             (ss_ack),
    .ss_dout            (ss_dout),
    .ss_busy            (ss_busy),
    .savestate_load     (savestate_load),
    .savestate_load_ack (savestate_load_ack),
    .savestate_load_busy(savestate_load_busy),
    .savestate_load_ok  (savestate_load_ok),
    .savestate_load_err (savestate_load_err)
  );

endmodule

// ==== sim/tb_save_state_controller.sv ====
`timescale 1ns/10ps

module tb_save_state_controller;

  import ss_pkg::*;

  localparam int FIFO_DEPTH_W = 4;
  // every bridge write of the run, foreign region included
  localparam int TOTAL_WORDS = 38;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 200;
  // one ack per ss_req issued in the data phase
  localparam int TOTAL_ACKS = 8;

  logic                clk_74a;
  logic                reset;
  logic                bridge_wr;
  logic [31:0]         bridge_addr;
  logic [BRIDGE_W-1:0] bridge_wr_data;
  logic                ss_req;
  logic                ss_busy;
  logic                savestate_load;
  logic                ss_load;
  logic                ss_ack;
  logic [SS_W-1:0]     ss_dout;
  logic                savestate_load_ack;
  logic                savestate_load_busy;
  logic                savestate_load_ok;
  logic                savestate_load_err;

  integer      seed;
  int          error_count;
  int          check_count;
  int          ack_count;
  int          load_count;
  logic [27:0] addr_offset;
  // words the core should see, oldest first
  ss_word_u    exp_q[$];

  save_state_controller #(
    .FIFO_DEPTH_W(FIFO_DEPTH_W)
  ) i_dut (
    .clk_74a            (clk_74a),
    .reset              (reset),
    .bridge_wr          (bridge_wr),
    .bridge_addr        (bridge_addr),
    .bridge_wr_data     (bridge_wr_data),
    .savestate_load     (savestate_load),
    .savestate_load_ack (savestate_load_ack),
    .savestate_load_busy(savestate_load_busy),
    .savestate_load_ok  (savestate_load_ok),
    .savestate_load_err (savestate_load_err),
    .ss_load            (ss_load),
    .ss_req             (ss_req),
    .ss_ack             (ss_ack),
    .ss_dout            (ss_dout),
    .ss_busy            (ss_busy)
  );

  initial begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  // big endian bridge word into core lane order
  function automatic logic [31:0] swap_bytes32(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // reference model, first word of the pair lands in the low half
  function automatic ss_word_u expected_word(input logic [31:0] first,
                                             input logic [31:0] second);
    ss_word_u w;
    w.halves[0] = swap_bytes32(first);
    w.halves[1] = swap_bytes32(second);
    return w;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic note_failure(input string msg);
    error_count++;
    $display("failure at %0t: %s", $time, msg);
  endtask

  // inputs change 2 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk_74a);
    #2;
  endtask

  task automatic write_region_word(input logic [31:0] data);
    bridge_wr      = 1'b1;
    bridge_addr    = {REGION_NIBBLE, addr_offset};
    bridge_wr_data = data;
    step_cycle();
    bridge_wr   = 1'b0;
    addr_offset = addr_offset + 28'd4;
  endtask

  // same strobe, other region, must be ignored
  task automatic write_foreign_word(input logic [3:0] nibble, input logic [31:0] data);
    bridge_wr      = 1'b1;
    bridge_addr    = {nibble, addr_offset};
    bridge_wr_data = data;
    step_cycle();
    bridge_wr = 1'b0;
  endtask

  task automatic write_random_pair();
    logic [31:0] first;
    logic [31:0] second;
    first  = $random(seed);
    second = $random(seed);
    write_region_word(first);
    write_region_word(second);
    exp_q.push_back(expected_word(first, second));
  endtask

  // request while a pair is stored, ack due exactly 2 cycles later
  task automatic request_timed();
    ss_req = 1'b1;
    step_cycle();
    ss_req = 1'b0;
    check_value("ss_ack", 64'(ss_ack), 64'd0);
    step_cycle();
    check_value("ss_ack", 64'(ss_ack), 64'd1);
  endtask

  // compare every ack against the reference queue
  always @(negedge clk_74a) begin
    if (!reset && ss_ack) begin
      ack_count++;
      if (exp_q.size() == 0) begin
        note_failure("ss_ack pulsed while no word was expected");
      end else begin
        check_value("ss_dout", ss_dout, exp_q.pop_front());
      end
    end
    if (!reset && ss_load) begin
      load_count++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_74a);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int          ack_before;
    int          load_before;
    int          wait_cycles;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    seed           = 32'haef2;
    error_count    = 0;
    check_count    = 0;
    ack_count      = 0;
    load_count     = 0;
    addr_offset    = '0;
    reset          = 1'b1;
    bridge_wr      = 1'b0;
    bridge_addr    = '0;
    bridge_wr_data = '0;
    ss_req         = 1'b0;
    ss_busy        = 1'b0;
    savestate_load = 1'b0;
    repeat (5) @(posedge clk_74a);
    #2;
    reset = 1'b0;
    step_cycle();

    // session start, ss_load one cycle after the pair is visible
    write_random_pair();
    check_value("ss_load", 64'(ss_load), 64'd0);
    step_cycle();
    check_value("ss_load", 64'(ss_load), 64'd1);
    step_cycle();
    check_value("ss_load", 64'(ss_load), 64'd0);
    repeat (3) step_cycle();
    check_value("load_count", 64'(load_count), 64'd1);
    ss_busy = 1'b1;
    request_timed();

    // data order and format
    repeat (4) write_random_pair();
    repeat (4) begin
      request_timed();
      step_cycle();
    end

    // early request, FIFO drained
    ack_before = ack_count;
    ss_req = 1'b1;
    step_cycle();
    ss_req = 1'b0;
    repeat (3) step_cycle();
    check_value("ack_count", 64'(ack_count), 64'(ack_before));
    write_random_pair();
    wait_cycles = 0;
    while (ack_count == ack_before && wait_cycles < 20) begin
      step_cycle();
      wait_cycles++;
    end
    if (ack_count == ack_before) begin
      note_failure("no ss_ack after an early ss_req and a late pair");
    end

    // region filter with foreign writes in between
    ack_before = ack_count;
    w0 = $random(seed);
    w1 = $random(seed);
    w2 = $random(seed);
    w3 = $random(seed);
    write_region_word(w0);
    write_foreign_word(4'h0, $random(seed));
    write_region_word(w1);
    write_foreign_word(4'h5, $random(seed));
    write_region_word(w2);
    write_foreign_word(4'hc, $random(seed));
    write_foreign_word(4'h3, $random(seed));
    write_region_word(w3);
    exp_q.push_back(expected_word(w0, w1));
    exp_q.push_back(expected_word(w2, w3));
    step_cycle();
    check_value("ack_count", 64'(ack_count), 64'(ack_before));
    request_timed();
    step_cycle();
    request_timed();
    step_cycle();

    // host handshake after the manager goes idle
    ss_busy = 1'b0;
    repeat (2) step_cycle();
    savestate_load = 1'b1;
    step_cycle();
    check_value("savestate_load_ack", 64'(savestate_load_ack), 64'd1);
    check_value("savestate_load_busy", 64'(savestate_load_busy), 64'd0);
    check_value("savestate_load_ok", 64'(savestate_load_ok), 64'd0);
    step_cycle();
    check_value("savestate_load_ack", 64'(savestate_load_ack), 64'd0);
    check_value("savestate_load_busy", 64'(savestate_load_busy), 64'd1);
    check_value("savestate_load_ok", 64'(savestate_load_ok), 64'd0);
    step_cycle();
    check_value("savestate_load_busy", 64'(savestate_load_busy), 64'd0);
    check_value("savestate_load_ok", 64'(savestate_load_ok), 64'd1);
    repeat (3) step_cycle();
    check_value("savestate_load_ok", 64'(savestate_load_ok), 64'd1);
    check_value("savestate_load_err", 64'(savestate_load_err), 64'd0);
    savestate_load = 1'b0;
    step_cycle();

    // overflow, 18 words into a 16 word FIFO with nobody reading
    load_before = load_count;
    repeat (18) write_region_word($random(seed));
    repeat (2) step_cycle();
    check_value("load_count", 64'(load_count), 64'(load_before + 1));
    check_value("savestate_load_err", 64'(savestate_load_err), 64'd1);
    check_value("savestate_load_ok", 64'(savestate_load_ok), 64'd0);

    if (exp_q.size() != 0) begin
      note_failure("expected words were never delivered on ss_dout");
    end
    check_value("ack_count", 64'(ack_count), 64'(TOTAL_ACKS));

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
src/ss_pkg.sv
src/ss_write_fifo.sv
src/ss_load_sequencer.sv
src/save_state_controller.sv
sim/tb_save_state_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the save state controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f sources.f \
  --top-module tb_save_state_controller \
  -o tb_save_state_controller
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_save_state_controller)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
